/* channel_demux.sv */
/*
 * picks the samples of one frame out of the held word and routes them,
 * lowest sample first, to the enabled channels in ascending order
 */

`timescale 1ns/1ps

module channel_demux (
  input  logic                           dac_clk,
  input  logic                           rst,
  unpack_if.demux                        slot,
  input  logic [upack_pkg::WORD_W-1:0]   word,
  output logic [upack_pkg::SAMPLE_W-1:0] ch_data_0,
  output logic [upack_pkg::SAMPLE_W-1:0] ch_data_1,
  output logic [upack_pkg::SAMPLE_W-1:0] ch_data_2,
  output logic [upack_pkg::SAMPLE_W-1:0] ch_data_3,
  output logic                           ch_valid_0,
  output logic                           ch_valid_1,
  output logic                           ch_valid_2,
  output logic                           ch_valid_3,
  output logic                           xfer_out
);

  import upack_pkg::*;

  logic [CNT_W-1:0]    k;
  logic [CNT_W-1:0]    base;
  logic [CNT_W-1:0]    rank;
  logic [CNT_W-1:0]    pos;
  logic [SAMPLE_W-1:0] data_nxt [CH_NUM];

  // ****************************************
  // sample selection
  // ****************************************

  // frame j starts at sample j*k, rank counts enabled channels below c
  always_comb begin
    k    = ch_count(slot.mask);
    base = CNT_W'(slot.frame) * k;
    rank = '0;
    pos  = '0;
    for (int c = 0; c < CH_NUM; c++) begin
      pos         = base + rank;
      data_nxt[c] = '0;
      if (slot.mask[c]) begin
        data_nxt[c] = word[pos[FRAME_W-1:0]*SAMPLE_W +: SAMPLE_W];
        rank        = rank + 1'b1;
      end
    end
  end

  // ****************************************
  // output registers
  // ****************************************

  always_ff @(posedge dac_clk) begin
    if (rst) begin
      ch_data_0  <= '0;
      ch_data_1  <= '0;
      ch_data_2  <= '0;
      ch_data_3  <= '0;
      ch_valid_0 <= 1'b0;
      ch_valid_1 <= 1'b0;
      ch_valid_2 <= 1'b0;
      ch_valid_3 <= 1'b0;
      xfer_out   <= 1'b0;
    end else begin
      // data holds between frames, disabled channels load zero
      if (slot.slot_valid) begin
        ch_data_0 <= data_nxt[0];
        ch_data_1 <= data_nxt[1];
        ch_data_2 <= data_nxt[2];
        ch_data_3 <= data_nxt[3];
      end
      ch_valid_0 <= slot.slot_valid && slot.mask[0];
      ch_valid_1 <= slot.slot_valid && slot.mask[1];
      ch_valid_2 <= slot.slot_valid && slot.mask[2];
      ch_valid_3 <= slot.slot_valid && slot.mask[3];
      xfer_out   <= slot.xfer;
    end
  end

endmodule

/* dac_upack.f */
+incdir+.
upack_pkg.sv
unpack_if.sv
upack_ctrl.sv
frame_cnt.sv
word_buffer.sv
channel_demux.sv
dac_upack.sv
upack_chk.sv
upack_scoreboard.sv
tb_dac_upack.sv

/* dac_upack.sv */
/*
 * DAC sample unpacker top level: splits 64-bit FIFO words into frames
 * of one sample per enabled channel, three cycles after each request
 */

`timescale 1ns/1ps

module dac_upack (
  input  logic                           dac_clk,
  input  logic                           rst,
  input  logic                           dac_req,
  input  logic [upack_pkg::CH_NUM-1:0]   enable,
  input  logic                           dma_xfer_in,
  input  logic [upack_pkg::WORD_W-1:0]   fifo_data,
  output logic                           fifo_rd,
  output logic [upack_pkg::SAMPLE_W-1:0] ch_data_0,
  output logic [upack_pkg::SAMPLE_W-1:0] ch_data_1,
  output logic [upack_pkg::SAMPLE_W-1:0] ch_data_2,
  output logic [upack_pkg::SAMPLE_W-1:0] ch_data_3,
  output logic                           ch_valid_0,
  output logic                           ch_valid_1,
  output logic                           ch_valid_2,
  output logic                           ch_valid_3,
  output logic                           xfer_out,
  output logic                           cfg_error
);

  import upack_pkg::*;

  logic               cnt_adv;
  logic [FRAME_W-1:0] cnt_frame;
  logic               cnt_wrap;
  logic [WORD_W-1:0]  word;

  // controller to buffer, buffer to demux
  unpack_if slot_a ();
  unpack_if slot_b ();

  upack_ctrl u_ctrl (
    .dac_clk     (dac_clk),
    .rst         (rst),
    .dac_req     (dac_req),
    .enable      (enable),
    .dma_xfer_in (dma_xfer_in),
    .fifo_rd     (fifo_rd),
    .cfg_error   (cfg_error),
    .cnt_adv     (cnt_adv),
    .cnt_frame   (cnt_frame),
    .cnt_wrap    (cnt_wrap),
    .slot        (slot_a.ctrl)
  );

  // mask is constant between resets, so the live enable sets the count
  frame_cnt u_frame_cnt (
    .dac_clk (dac_clk),
    .rst     (rst),
    .adv     (cnt_adv),
    .mask    (enable),
    .frame   (cnt_frame),
    .wrap    (cnt_wrap)
  );

  word_buffer u_word_buffer (
    .dac_clk   (dac_clk),
    .rst       (rst),
    .fifo_data (fifo_data),
    .slot_in   (slot_a.buffer),
    .slot_out  (slot_b.ctrl),
    .word      (word)
  );

  channel_demux u_channel_demux (
    .dac_clk    (dac_clk),
    .rst        (rst),
    .slot       (slot_b.demux),
    .word       (word),
    .ch_data_0  (ch_data_0),
    .ch_data_1  (ch_data_1),
    .ch_data_2  (ch_data_2),
    .ch_data_3  (ch_data_3),
    .ch_valid_0 (ch_valid_0),
    .ch_valid_1 (ch_valid_1),
    .ch_valid_2 (ch_valid_2),
    .ch_valid_3 (ch_valid_3),
    .xfer_out   (xfer_out)
  );

endmodule

/* frame_cnt.sv */
/*
 * frame position inside the current FIFO word, advanced once per
 * accepted request and wrapped after the last frame of the word
 */

`timescale 1ns/1ps

module frame_cnt (
  input  logic                          dac_clk,
  input  logic                          rst,
  input  logic                          adv,
  input  logic [upack_pkg::CH_NUM-1:0]  mask,
  output logic [upack_pkg::FRAME_W-1:0] frame,
  output logic                          wrap
);

  import upack_pkg::*;

  logic [FRAME_W-1:0] last;

  // frames per word minus one, from the number of enabled channels
  always_comb begin
    case (ch_count(mask))
      3'd1:    last = 2'd3;
      3'd2:    last = 2'd1;
      default: last = 2'd0;
    endcase
  end

  assign wrap = (frame == last);

  always_ff @(posedge dac_clk) begin
    if (rst) begin
      frame <= '0;
    end else if (adv) begin
      if (wrap) begin
        frame <= '0;
      end else begin
        frame <= frame + 1'b1;
      end
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# build the unpacker testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f dac_upack.f --top-module tb_dac_upack
out=$(./obj_dir/Vtb_dac_upack)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'TEST OK'; then
  exit 0
else
  exit 1
fi

/* upack_pattern.svh */
/*
 * FIFO data pattern used by the FIFO model and the scoreboard, where every
 * sample depends on the whole word number and its place in the word
 */

function automatic logic [SAMPLE_W-1:0] sample_of(input int n, input int s);
  return SAMPLE_W'((n << 2) + s) ^ 16'hc35a;
endfunction

function automatic logic [WORD_W-1:0] word_of(input int n);
  logic [WORD_W-1:0] w;
  for (int s = 0; s < CH_NUM; s++) begin
    w[s*SAMPLE_W +: SAMPLE_W] = sample_of(n, s);
  end
  return w;
endfunction

/* tb_dac_upack.sv */
/*
 * testbench for the DAC sample unpacker: clock, reset, FIFO model,
 * request stimulus and timeout, with the scoreboard doing the checks
 */

`timescale 1ns/1ps

module tb_dac_upack;

  import upack_pkg::*;

  `include "upack_pattern.svh"

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 8;
  localparam int DRAIN      = 5;
  localparam int MAX_GAP    = 3;
  localparam int NUM_TESTS  = 6;
  localparam int TOTAL_REQS = 8 + 8 + 10 + 16 + 6 + 8;
  localparam int TIMEOUT    = TOTAL_REQS * (MAX_GAP + 1)
                              + NUM_TESTS * (RST_CYCLES + DRAIN + 1) + 100;
  localparam logic [CH_NUM-1:0] MASK_CHOICES [6] = '{4'b1111, 4'b0110, 4'b1001,
                                                     4'b0001, 4'b1000, 4'b0101};

  logic                dac_clk     = 1'b0;
  logic                rst         = 1'b1;
  logic                dac_req     = 1'b0;
  logic [CH_NUM-1:0]   enable      = 4'b1111;
  logic                dma_xfer_in = 1'b0;
  logic [WORD_W-1:0]   fifo_data   = '0;
  logic                fifo_rd;
  logic [SAMPLE_W-1:0] ch_data_0, ch_data_1, ch_data_2, ch_data_3;
  logic                ch_valid_0, ch_valid_1, ch_valid_2, ch_valid_3;
  logic                xfer_out;
  logic                cfg_error;
  integer              seed      = 32'h9c85_c5c8;
  int                  rd_cnt    = 0;
  int                  cycle_cnt = 0;
  int                  test_num  = 0;
  logic                test_end  = 1'b0;
  int                  chk_total;
  int                  err_total;

  dac_upack u_dut (.*);

  upack_scoreboard u_sb (.*);

  initial begin
    forever #(CLK_PERIOD / 2) dac_clk = ~dac_clk;
  end

  // FIFO answers each read one cycle later with the next word
  always @(posedge dac_clk) begin
    if (rst) begin
      rd_cnt    <= 0;
      fifo_data <= '0;
    end else if (fifo_rd) begin
      fifo_data <= word_of(rd_cnt);
      rd_cnt    <= rd_cnt + 1;
    end
  end

  always @(posedge dac_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("timeout: the run did not complete within %0d cycles", TIMEOUT);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ****************************************
  // stimulus
  // ****************************************

  // the mask only changes while reset is held
  task automatic apply_reset(input logic [CH_NUM-1:0] mask);
    rst     <= 1'b1;
    dac_req <= 1'b0;
    enable  <= mask;
    repeat (RST_CYCLES) @(posedge dac_clk);
    rst <= 1'b0;
  endtask

  task automatic send_requests(input int count, input int max_gap);
    int          gap;
    logic [31:0] rnd;
    for (int i = 0; i < count; i++) begin
      rnd = $random(seed);
      dac_req     <= 1'b1;
      dma_xfer_in <= rnd[0];
      @(posedge dac_clk);
      dac_req <= 1'b0;
      gap = (max_gap == 0) ? 0 : $unsigned($random(seed)) % (max_gap + 1);
      repeat (gap) @(posedge dac_clk);
    end
  endtask

  // outputs trail the last request by the three cycle latency
  task automatic end_test(input int num);
    repeat (DRAIN) @(posedge dac_clk);
    test_num <= num;
    test_end <= 1'b1;
    @(posedge dac_clk);
    test_end <= 1'b0;
  endtask

  initial begin
    int idx;
    apply_reset(4'b1111);
    send_requests(8, 0);
    end_test(1);
    apply_reset(4'b1010);
    send_requests(8, 0);
    end_test(2);
    // stops in the middle of a word so the next reset has a frame to clear
    apply_reset(4'b0100);
    send_requests(10, 0);
    end_test(3);
    idx = $unsigned($random(seed)) % 6;
    apply_reset(MASK_CHOICES[idx]);
    send_requests(16, MAX_GAP);
    end_test(4);
    // three channels, then recovery from word 0
    apply_reset(4'b0111);
    send_requests(6, 1);
    end_test(5);
    apply_reset(4'b0011);
    send_requests(8, 0);
    end_test(6);
    $display("all tests done: %0d checks, %0d errors", chk_total, err_total);
    if ((err_total == 0) && (chk_total > 0)) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* unpack_if.sv */
/*
 * one pipeline slot of the unpacker: request valid, word load flag,
 * frame index, channel mask and DMA transfer flag
 */

`timescale 1ns/1ps

interface unpack_if;

  import upack_pkg::*;

  logic               slot_valid;
  logic               load;
  logic [FRAME_W-1:0] frame;
  logic [CH_NUM-1:0]  mask;
  logic               xfer;

  // producer side, controller or the output stage of the buffer
  modport ctrl (
    output slot_valid,
    output load,
    output frame,
    output mask,
    output xfer
  );

  // word buffer input side
  modport buffer (
    input slot_valid,
    input load,
    input frame,
    input mask,
    input xfer
  );

  // demux only needs the frame position, not the load flag
  modport demux (
    input slot_valid,
    input frame,
    input mask,
    input xfer
  );

endinterface

/* upack_chk.sv */
/*
 * protocol assertions for the unpacker, bound into the top level
 */

`timescale 1ns/1ps

module upack_chk (
  input logic                         dac_clk,
  input logic                         rst,
  input logic                         dac_req,
  input logic [upack_pkg::CH_NUM-1:0] enable,
  input logic                         fifo_rd,
  input logic                         ch_valid_0, ch_valid_1, ch_valid_2, ch_valid_3,
  input logic                         xfer_out,
  input logic                         cfg_error
);

  import upack_pkg::*;

  logic [CH_NUM-1:0] valids;

  assign valids = {ch_valid_3, ch_valid_2, ch_valid_1, ch_valid_0};

  // a FIFO read comes from the request one edge earlier
  rd_after_req: assert property (@(posedge dac_clk) disable iff (rst)
    fifo_rd |-> $past(dac_req))
    else $error("fifo_rd raised without a request on the previous edge");

  valid_enabled: assert property (@(posedge dac_clk) disable iff (rst)
    (valids & ~enable) == '0)
    else $error("ch_valid set on a disabled channel");

  // error state only leaves through reset
  err_sticky: assert property (@(posedge dac_clk) $fell(cfg_error) |-> $past(rst))
    else $error("cfg_error dropped without a reset");

  reset_quiet: assert property (@(posedge dac_clk)
    $past(rst) |-> (!fifo_rd && (valids == '0) && !xfer_out && !cfg_error))
    else $error("outputs active during reset");

endmodule

bind dac_upack upack_chk u_chk (
  .dac_clk    (dac_clk),
  .rst        (rst),
  .dac_req    (dac_req),
  .enable     (enable),
  .fifo_rd    (fifo_rd),
  .ch_valid_0 (ch_valid_0),
  .ch_valid_1 (ch_valid_1),
  .ch_valid_2 (ch_valid_2),
  .ch_valid_3 (ch_valid_3),
  .xfer_out   (xfer_out),
  .cfg_error  (cfg_error)
);

/* upack_ctrl.sv */
/*
 * request controller: checks the channel mask on the first request,
 * then turns every accepted request into a pipeline slot and a FIFO
 * read whenever the slot starts a new word
 */

`timescale 1ns/1ps

module upack_ctrl (
  input  logic                        dac_clk,
  input  logic                        rst,
  input  logic                        dac_req,
  input  logic [upack_pkg::CH_NUM-1:0] enable,
  input  logic                        dma_xfer_in,
  output logic                        fifo_rd,
  output logic                        cfg_error,
  output logic                        cnt_adv,
  input  logic [upack_pkg::FRAME_W-1:0] cnt_frame,
  input  logic                        cnt_wrap,
  unpack_if.ctrl                      slot
);

  import upack_pkg::*;

  upack_state_t      state;
  upack_state_t      state_nxt;
  logic [CNT_W-1:0]  en_cnt;
  logic              mask_ok;
  logic              accept;
  logic [CH_NUM-1:0] mask_q;
  // next accepted request opens a new word
  logic              need_word;

  // only 1, 2 or 4 channels split a word into whole frames
  assign en_cnt  = ch_count(enable);
  assign mask_ok = (en_cnt == 3'd1) || (en_cnt == 3'd2) || (en_cnt == 3'd4);

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (dac_req) begin
          state_nxt = mask_ok ? st_run : st_bad;
        end
      end
      st_run:  state_nxt = st_run;
      default: state_nxt = st_bad;
    endcase
  end

  // the first request is served in the same edge that leaves idle
  assign accept  = dac_req && ((state == st_run) || ((state == st_idle) && mask_ok));
  assign cnt_adv = accept;

  // ****************************************
  // state and slot registers
  // ****************************************

  always_ff @(posedge dac_clk) begin
    if (rst) begin
      state           <= st_idle;
      cfg_error       <= 1'b0;
      fifo_rd         <= 1'b0;
      mask_q          <= '0;
      need_word       <= 1'b1;
      slot.slot_valid <= 1'b0;
      slot.load       <= 1'b0;
      slot.frame      <= '0;
      slot.xfer       <= 1'b0;
    end else begin
      state     <= state_nxt;
      cfg_error <= (state_nxt == st_bad);
      fifo_rd   <= accept && need_word;
      if ((state == st_idle) && dac_req && mask_ok) begin
        mask_q <= enable;
      end
      if (accept) begin
        need_word <= cnt_wrap;
      end
      slot.slot_valid <= accept;
      slot.load       <= accept && need_word;
      slot.frame      <= cnt_frame;
      // transfer flag runs with the pipeline every cycle
      slot.xfer       <= dma_xfer_in;
    end
  end

  assign slot.mask = mask_q;

endmodule

/* upack_pkg.sv */
/*
 * shared sizes, controller states and the channel count helper for the
 * four-channel DAC sample unpacker
 */

package upack_pkg;

  // ****************************************
  // sizes
  // ****************************************

  localparam int CH_NUM   = 4;
  localparam int SAMPLE_W = 16;
  localparam int WORD_W   = CH_NUM * SAMPLE_W;
  localparam int FRAME_W  = 2;
  // wide enough to hold a count of 0 to CH_NUM enabled channels
  localparam int CNT_W    = 3;

  // controller states
  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_bad
  } upack_state_t;

  // number of set bits in a channel mask
  function automatic logic [CNT_W-1:0] ch_count(input logic [CH_NUM-1:0] m);
    logic [CNT_W-1:0] n;
    n = '0;
    for (int i = 0; i < CH_NUM; i++) begin
      n = n + CNT_W'(m[i]);
    end
    return n;
  endfunction

endpackage

/* upack_scoreboard.sv */
/*
 * scoreboard of the unpacker testbench: follows the request stream,
 * predicts every DUT output from the unpacking rules and counts mismatches
 */

`timescale 1ns/1ps

module upack_scoreboard (
  input  logic                           dac_clk,
  input  logic                           rst,
  input  logic                           dac_req,
  input  logic [upack_pkg::CH_NUM-1:0]   enable,
  input  logic                           dma_xfer_in,
  input  logic                           fifo_rd,
  input  logic [upack_pkg::SAMPLE_W-1:0] ch_data_0, ch_data_1, ch_data_2, ch_data_3,
  input  logic                           ch_valid_0, ch_valid_1, ch_valid_2, ch_valid_3,
  input  logic                           xfer_out,
  input  logic                           cfg_error,
  input  int                             test_num,
  input  logic                           test_end,
  output int                             chk_total,
  output int                             err_total
);

  import upack_pkg::*;

  `include "upack_pattern.svh"

  localparam int LAT = 3;
  localparam int VW  = CH_NUM * SAMPLE_W + CH_NUM;

  logic              ref_run;
  logic              ref_bad;
  logic [CH_NUM-1:0] ref_mask;
  int                req_cnt;
  int                en_n;
  logic              acc;
  logic              want_rd;
  // requests in flight, entry LAT lines up with the outputs
  logic              p_req  [LAT+1];
  int                p_num  [LAT+1];
  logic [CH_NUM-1:0] p_mask [LAT+1];
  logic              p_xfer [LAT+1];
  logic [VW-1:0]     want;
  int                chk_cnt  = 0;
  int                err_cnt  = 0;
  int                test_chk = 0;
  int                test_err = 0;

  assign chk_total = chk_cnt;
  assign err_total = err_cnt;

  function automatic int bit_count(input logic [CH_NUM-1:0] m);
    int n;
    n = 0;
    for (int c = 0; c < CH_NUM; c++) begin
      if (m[c]) begin
        n++;
      end
    end
    return n;
  endfunction

  // valids on top, samples below; frame r%fpw of word r/fpw
  function automatic logic [VW-1:0] expect_frame(input int r, input logic [CH_NUM-1:0] m);
    int            k;
    int            fpw;
    int            rank;
    logic [VW-1:0] res;
    k    = bit_count(m);
    fpw  = (k == 0) ? 1 : CH_NUM / k;
    rank = 0;
    res  = '0;
    for (int c = 0; c < CH_NUM; c++) begin
      if (m[c]) begin
        res[c*SAMPLE_W +: SAMPLE_W] = sample_of(r / fpw, (r % fpw) * k + rank);
        res[CH_NUM*SAMPLE_W + c]    = 1'b1;
        rank++;
      end
    end
    return res;
  endfunction

  task automatic check_value(input string what, input logic [SAMPLE_W-1:0] got,
                             input logic [SAMPLE_W-1:0] exp);
    chk_cnt++;
    test_chk++;
    if (got !== exp) begin
      err_cnt++;
      test_err++;
      $display("ERROR t=%0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ****************************************
  // reference controller, one step per edge
  // ****************************************

  always @(posedge dac_clk) begin
    for (int i = LAT; i > 0; i--) begin
      p_req[i]  = p_req[i-1];
      p_num[i]  = p_num[i-1];
      p_mask[i] = p_mask[i-1];
      p_xfer[i] = p_xfer[i-1];
    end
    acc     = 1'b0;
    want_rd = 1'b0;
    if (rst) begin
      ref_run = 1'b0;
      ref_bad = 1'b0;
      req_cnt = 0;
      for (int i = 0; i <= LAT; i++) begin
        p_req[i]  = 1'b0;
        p_xfer[i] = 1'b0;
      end
    end else begin
      // the first request decides between running and the error state
      if (dac_req && !ref_run && !ref_bad) begin
        en_n     = bit_count(enable);
        ref_mask = enable;
        ref_run  = (en_n == 1) || (en_n == 2) || (en_n == 4);
        ref_bad  = !ref_run;
      end
      acc       = dac_req && ref_run;
      p_req[0]  = acc;
      p_num[0]  = req_cnt;
      p_mask[0] = ref_mask;
      p_xfer[0] = dma_xfer_in;
      if (acc) begin
        want_rd = (req_cnt % (CH_NUM / bit_count(ref_mask))) == 0;
        req_cnt++;
      end
    end
  end

  // outputs are settled at the falling edge
  always @(negedge dac_clk) begin
    want = p_req[LAT] ? expect_frame(p_num[LAT], p_mask[LAT]) : '0;
    check_value("ch_valid", SAMPLE_W'({ch_valid_3, ch_valid_2, ch_valid_1, ch_valid_0}),
                SAMPLE_W'(want[CH_NUM*SAMPLE_W +: CH_NUM]));
    if (p_req[LAT]) begin
      check_value("ch_data_0", ch_data_0, want[0*SAMPLE_W +: SAMPLE_W]);
      check_value("ch_data_1", ch_data_1, want[1*SAMPLE_W +: SAMPLE_W]);
      check_value("ch_data_2", ch_data_2, want[2*SAMPLE_W +: SAMPLE_W]);
      check_value("ch_data_3", ch_data_3, want[3*SAMPLE_W +: SAMPLE_W]);
    end
    check_value("xfer_out", SAMPLE_W'(xfer_out), SAMPLE_W'(p_xfer[LAT]));
    check_value("fifo_rd", SAMPLE_W'(fifo_rd), SAMPLE_W'(want_rd));
    check_value("cfg_error", SAMPLE_W'(cfg_error), SAMPLE_W'(ref_bad));
    if (test_end) begin
      $display("test %0d finished: %0d checks, %0d errors", test_num, test_chk, test_err);
      test_chk = 0;
      test_err = 0;
    end
  end

endmodule

/* word_buffer.sv */
/*
 * store and forward stage: waits out the FIFO read latency, captures
 * the new word on a load slot and otherwise keeps the held word
 */

`timescale 1ns/1ps

module word_buffer (
  input  logic                         dac_clk,
  input  logic                         rst,
  input  logic [upack_pkg::WORD_W-1:0] fifo_data,
  unpack_if.buffer                     slot_in,
  unpack_if.ctrl                       slot_out,
  output logic [upack_pkg::WORD_W-1:0] word
);

  import upack_pkg::*;

  // slot delayed by one cycle, lined up with fifo_data
  logic               d_valid;
  logic               d_load;
  logic [FRAME_W-1:0] d_frame;
  logic [CH_NUM-1:0]  d_mask;
  logic               d_xfer;

  always_ff @(posedge dac_clk) begin
    if (rst) begin
      d_valid             <= 1'b0;
      d_load              <= 1'b0;
      d_xfer              <= 1'b0;
      slot_out.slot_valid <= 1'b0;
      slot_out.load       <= 1'b0;
      slot_out.xfer       <= 1'b0;
    end else begin
      d_valid             <= slot_in.slot_valid;
      d_load              <= slot_in.load;
      d_xfer              <= slot_in.xfer;
      slot_out.slot_valid <= d_valid;
      slot_out.load       <= d_load;
      slot_out.xfer       <= d_xfer;
    end
  end

  // frame, mask and word travel with the slot
  always_ff @(posedge dac_clk) begin
    d_frame        <= slot_in.frame;
    d_mask         <= slot_in.mask;
    slot_out.frame <= d_frame;
    slot_out.mask  <= d_mask;
    if (d_valid && d_load) begin
      word <= fifo_data;
    end
  end

endmodule
